//--- include/fb_params.svh
`ifndef FB_PARAMS_SVH
`define FB_PARAMS_SVH

// screen coordinates
`define FB_X_W 9
`define FB_Y_W 7

// one colour channel, same for r, g and b
`define FB_COLOR_W 6

// reads allowed between request accept and read data pop
`define FB_MAX_RD 4

// memory port widths
`define FB_ADDR_W 30
`define FB_WORD_W 32

// host bus
`define FB_AXI_ADDR_W 32

`endif

//--- source/fb_pkg.sv
`include "fb_params.svh"

package fb_pkg;

    // memory controller opcodes
    typedef enum logic [2:0] {
        MEM_WRITE = 3'd0,
        MEM_READ  = 3'd1
    } mem_instr_e;

    typedef enum logic [1:0] {
        ISSUE_IDLE,
        ISSUE_WR_DATA, // write word pushed here
        ISSUE_CMD      // command pushed here
    } issue_state_e;

    typedef struct packed {
        logic [`FB_COLOR_W-1:0] r;
        logic [`FB_COLOR_W-1:0] g;
        logic [`FB_COLOR_W-1:0] b;
    } pixel_t;

    typedef struct packed {
        logic [`FB_Y_W-1:0] y;
        logic [`FB_X_W-1:0] x;
    } pix_addr_t;

    typedef struct packed {
        pix_addr_t              addr;
        logic [`FB_WORD_W-1:0]  data;
        logic [`FB_WORD_W/8-1:0] mask; // memory polarity, 1 = byte kept
    } wr_req_t;

    typedef struct packed {
        mem_instr_e             instr;
        logic [5:0]             bl;
        logic [`FB_ADDR_W-1:0]  byte_addr;
    } mem_cmd_t;

endpackage

//--- source/fb_host_wr.sv
`timescale 1ns/1ps
`include "fb_params.svh"

module fb_host_wr
    import fb_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,

    // axi4-lite write channels
    input  logic                       s_awvalid_i,
    output logic                       s_awready_o,
    input  logic [`FB_AXI_ADDR_W-1:0]  s_awaddr_i,
    input  logic                       s_wvalid_i,
    output logic                       s_wready_o,
    input  logic [`FB_WORD_W-1:0]      s_wdata_i,
    input  logic [`FB_WORD_W/8-1:0]    s_wstrb_i,
    output logic                       s_bvalid_o,
    input  logic                       s_bready_i,
    output logic [1:0]                 s_bresp_o,

    // pixel write request
    output logic                       wr_valid_o,
    output wr_req_t                    wr_req_o,
    input  logic                       wr_ready_i
);

    pix_addr_t                  aw_addr_q;
    logic [`FB_WORD_W-1:0]      w_data_q;
    logic [`FB_WORD_W/8-1:0]    w_strb_q;

    logic aw_held_q, aw_held_d;
    logic w_held_q, w_held_d;
    logic wr_valid_q, wr_valid_d;
    logic bvalid_q, bvalid_d;
    logic awready_q, wready_q;

    logic aw_fire, w_fire, wr_fire, b_fire;

    assign aw_fire = s_awvalid_i && awready_q;
    assign w_fire  = s_wvalid_i && wready_q;
    assign wr_fire = wr_valid_q && wr_ready_i;
    assign b_fire  = bvalid_q && s_bready_i;

    always_comb begin
        aw_held_d  = aw_held_q;
        w_held_d   = w_held_q;
        wr_valid_d = wr_valid_q;
        bvalid_d   = bvalid_q;

        if (aw_fire) aw_held_d = 1'b1;
        if (w_fire)  w_held_d  = 1'b1;

        if (wr_fire) begin
            // both halves consumed, answer the host next cycle
            aw_held_d  = 1'b0;
            w_held_d   = 1'b0;
            wr_valid_d = 1'b0;
            bvalid_d   = 1'b1;
        end else if (aw_held_q && w_held_q) begin
            wr_valid_d = 1'b1;
        end

        if (b_fire) bvalid_d = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_held_q  <= 1'b0;
            w_held_q   <= 1'b0;
            wr_valid_q <= 1'b0;
            bvalid_q   <= 1'b0;
            awready_q  <= 1'b0;
            wready_q   <= 1'b0;
        end else begin
            aw_held_q  <= aw_held_d;
            w_held_q   <= w_held_d;
            wr_valid_q <= wr_valid_d;
            bvalid_q   <= bvalid_d;
            awready_q  <= !aw_held_d && !bvalid_d; // no new address until bresp is taken
            wready_q   <= !w_held_d;
        end
    end

    // holding registers
    always_ff @(posedge clk) begin
        if (aw_fire) aw_addr_q <= s_awaddr_i[$bits(pix_addr_t)+1:2];
        if (w_fire) begin
            w_data_q <= s_wdata_i;
            w_strb_q <= s_wstrb_i;
        end
    end

    assign s_awready_o = awready_q;
    assign s_wready_o  = wready_q;
    assign s_bvalid_o  = bvalid_q;
    assign s_bresp_o   = 2'b00; // always OKAY

    assign wr_valid_o    = wr_valid_q;
    assign wr_req_o.addr = aw_addr_q;
    assign wr_req_o.data = w_data_q;
    assign wr_req_o.mask = ~w_strb_q; // mig masks the disabled bytes

    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        s_bvalid_o && !s_bready_i |=> s_bvalid_o)
        else $error("bvalid dropped before bready");

endmodule

//--- source/fb_cmd_issue.sv
`timescale 1ns/1ps
`include "fb_params.svh"

module fb_cmd_issue
    import fb_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,

    // lcd read requests
    input  logic                       rd_valid_i,
    input  pix_addr_t                  rd_addr_i,
    output logic                       rd_ready_o,

    // host write requests
    input  logic                       wr_valid_i,
    input  wr_req_t                    wr_req_i,
    output logic                       wr_ready_o,

    // one pulse per read word popped
    input  logic                       rd_done_i,

    // memory command port
    output logic                       mem_cmd_en_o,
    output mem_cmd_t                   mem_cmd_o,
    input  logic                       mem_cmd_full_i,

    // memory write data port
    output logic                       mem_wr_en_o,
    output logic [`FB_WORD_W-1:0]      mem_wr_data_o,
    output logic [`FB_WORD_W/8-1:0]    mem_wr_mask_o,
    input  logic                       mem_wr_full_i
);

    localparam int CNT_W = $clog2(`FB_MAX_RD + 1);

    issue_state_e               state_q;
    mem_cmd_t                   cmd_q;
    logic [`FB_WORD_W-1:0]      wr_data_q;
    logic [`FB_WORD_W/8-1:0]    wr_mask_q;
    logic [CNT_W-1:0]           rd_cnt_q;

    logic rd_room;
    logic rd_take, wr_take;

    // pixel index to byte address, one 32-bit word per pixel
    function automatic logic [`FB_ADDR_W-1:0] to_byte_addr(input pix_addr_t a);
        return {{(`FB_ADDR_W - $bits(pix_addr_t) - 2){1'b0}}, a, 2'b00};
    endfunction

    assign rd_room = (rd_cnt_q < CNT_W'(`FB_MAX_RD));

    // reads win over writes
    assign rd_ready_o = (state_q == ISSUE_IDLE) && rd_room;
    assign wr_ready_o = (state_q == ISSUE_IDLE) && !(rd_valid_i && rd_room);

    assign rd_take = rd_valid_i && rd_ready_o;
    assign wr_take = wr_valid_i && wr_ready_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ISSUE_IDLE;
        end else begin
            case (state_q)
                ISSUE_IDLE: begin
                    if (rd_take) begin
                        state_q <= ISSUE_CMD;
                    end else if (wr_take) begin
                        state_q <= ISSUE_WR_DATA;
                    end
                end
                ISSUE_WR_DATA: begin
                    if (!mem_wr_full_i) state_q <= ISSUE_CMD; // data goes in before the command
                end
                ISSUE_CMD: begin
                    if (!mem_cmd_full_i) state_q <= ISSUE_IDLE;
                end
                default: state_q <= ISSUE_IDLE;
            endcase
        end
    end

    // selected request
    always_ff @(posedge clk) begin
        if (rd_take) begin
            cmd_q.instr     <= MEM_READ;
            cmd_q.bl        <= 6'd0; // bl is length minus one
            cmd_q.byte_addr <= to_byte_addr(rd_addr_i);
        end else if (wr_take) begin
            cmd_q.instr     <= MEM_WRITE;
            cmd_q.bl        <= 6'd0;
            cmd_q.byte_addr <= to_byte_addr(wr_req_i.addr);
            wr_data_q       <= wr_req_i.data;
            wr_mask_q       <= wr_req_i.mask;
        end
    end

    // reads counted from accept until the data word is popped
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_cnt_q <= '0;
        end else begin
            case ({rd_take, rd_done_i})
                2'b10:   rd_cnt_q <= rd_cnt_q + 1'b1;
                2'b01:   rd_cnt_q <= rd_cnt_q - 1'b1;
                default: rd_cnt_q <= rd_cnt_q;
            endcase
        end
    end

    assign mem_cmd_en_o  = (state_q == ISSUE_CMD) && !mem_cmd_full_i;
    assign mem_cmd_o     = cmd_q;
    assign mem_wr_en_o   = (state_q == ISSUE_WR_DATA) && !mem_wr_full_i;
    assign mem_wr_data_o = wr_data_q;
    assign mem_wr_mask_o = wr_mask_q;

    a_rd_limit: assert property (@(posedge clk) disable iff (rst)
        rd_cnt_q <= CNT_W'(`FB_MAX_RD))
        else $error("outstanding reads above limit");

endmodule

//--- source/fb_rd_unpack.sv
`timescale 1ns/1ps
`include "fb_params.svh"

module fb_rd_unpack
    import fb_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,

    // memory read port, first word falls through
    output logic                    mem_rd_en_o,
    input  logic [`FB_WORD_W-1:0]   mem_rd_data_i,
    input  logic                    mem_rd_empty_i,

    output logic                    rd_done_o,

    // lcd response, no back-pressure
    output logic                    resp_valid_o,
    output pixel_t                  resp_pix_o
);

    logic   pop;
    logic   pop_q;
    pixel_t pix_q;

    assign pop = !mem_rd_empty_i; // take every word as soon as it shows up

    always_ff @(posedge clk) begin
        if (rst) begin
            pop_q <= 1'b0;
        end else begin
            pop_q <= pop;
        end
    end

    // colour fields sit in the low bits of bytes 2, 1 and 0
    always_ff @(posedge clk) begin
        if (pop) begin
            pix_q.r <= mem_rd_data_i[16 +: `FB_COLOR_W];
            pix_q.g <= mem_rd_data_i[8 +: `FB_COLOR_W];
            pix_q.b <= mem_rd_data_i[0 +: `FB_COLOR_W];
        end
    end

    assign mem_rd_en_o  = pop;
    assign rd_done_o    = pop_q;
    assign resp_valid_o = pop_q;
    assign resp_pix_o   = pix_q;

    a_pop_data_known: assert property (@(posedge clk) disable iff (rst)
        mem_rd_en_o |-> !$isunknown(mem_rd_data_i))
        else $error("read FIFO popped with unknown data");

endmodule

//--- source/fb_top.sv
`timescale 1ns/1ps
`include "fb_params.svh"

module fb_top
    import fb_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,

    // host, axi4-lite write only
    input  logic                       s_awvalid_i,
    output logic                       s_awready_o,
    input  logic [`FB_AXI_ADDR_W-1:0]  s_awaddr_i,
    input  logic                       s_wvalid_i,
    output logic                       s_wready_o,
    input  logic [`FB_WORD_W-1:0]      s_wdata_i,
    input  logic [`FB_WORD_W/8-1:0]    s_wstrb_i,
    output logic                       s_bvalid_o,
    input  logic                       s_bready_i,
    output logic [1:0]                 s_bresp_o,

    // lcd controller
    input  logic                       req_valid_i,
    input  pix_addr_t                  req_addr_i,
    output logic                       req_ready_o,
    output logic                       resp_valid_o,
    output pixel_t                     resp_pix_o,

    // mig style memory port
    output logic                       mem_cmd_en_o,
    output mem_cmd_t                   mem_cmd_o,
    input  logic                       mem_cmd_full_i,
    output logic                       mem_wr_en_o,
    output logic [`FB_WORD_W-1:0]      mem_wr_data_o,
    output logic [`FB_WORD_W/8-1:0]    mem_wr_mask_o,
    input  logic                       mem_wr_full_i,
    output logic                       mem_rd_en_o,
    input  logic [`FB_WORD_W-1:0]      mem_rd_data_i,
    input  logic                       mem_rd_empty_i
);

    logic    wr_valid;
    logic    wr_ready;
    wr_req_t wr_req;
    logic    rd_done;

    fb_host_wr i_host_wr (
        .clk         (clk),
        .rst         (rst),
        .s_awvalid_i (s_awvalid_i),
        .s_awready_o (s_awready_o),
        .s_awaddr_i  (s_awaddr_i),
        .s_wvalid_i  (s_wvalid_i),
        .s_wready_o  (s_wready_o),
        .s_wdata_i   (s_wdata_i),
        .s_wstrb_i   (s_wstrb_i),
        .s_bvalid_o  (s_bvalid_o),
        .s_bready_i  (s_bready_i),
        .s_bresp_o   (s_bresp_o),
        .wr_valid_o  (wr_valid),
        .wr_req_o    (wr_req),
        .wr_ready_i  (wr_ready)
    );

    fb_cmd_issue i_cmd_issue (
        .clk            (clk),
        .rst            (rst),
        .rd_valid_i     (req_valid_i),
        .rd_addr_i      (req_addr_i),
        .rd_ready_o     (req_ready_o),
        .wr_valid_i     (wr_valid),
        .wr_req_i       (wr_req),
        .wr_ready_o     (wr_ready),
        .rd_done_i      (rd_done),
        .mem_cmd_en_o   (mem_cmd_en_o),
        .mem_cmd_o      (mem_cmd_o),
        .mem_cmd_full_i (mem_cmd_full_i),
        .mem_wr_en_o    (mem_wr_en_o),
        .mem_wr_data_o  (mem_wr_data_o),
        .mem_wr_mask_o  (mem_wr_mask_o),
        .mem_wr_full_i  (mem_wr_full_i)
    );

    fb_rd_unpack i_rd_unpack (
        .clk            (clk),
        .rst            (rst),
        .mem_rd_en_o    (mem_rd_en_o),
        .mem_rd_data_i  (mem_rd_data_i),
        .mem_rd_empty_i (mem_rd_empty_i),
        .rd_done_o      (rd_done),
        .resp_valid_o   (resp_valid_o),
        .resp_pix_o     (resp_pix_o)
    );

endmodule

//--- test/mig_port_model.sv
`timescale 1ns/1ps
`include "fb_params.svh"

module mig_port_model
    import fb_pkg::*;
#(
    parameter int SEED = 14443
) (
    input  logic                       clk,
    input  logic                       rst,

    // command port
    input  logic                       cmd_en_i,
    input  mem_cmd_t                   cmd_i,
    output logic                       cmd_full_o,

    // write data port, mask bit set means byte not written
    input  logic                       wr_en_i,
    input  logic [`FB_WORD_W-1:0]      wr_data_i,
    input  logic [`FB_WORD_W/8-1:0]    wr_mask_i,
    output logic                       wr_full_o,

    // read data port, first word falls through
    input  logic                       rd_en_i,
    output logic [`FB_WORD_W-1:0]      rd_data_o,
    output logic                       rd_empty_o
);

    localparam int DEPTH = 8;

    logic [`FB_WORD_W-1:0]                  mem [int];
    mem_cmd_t                               cmd_q [$];
    logic [`FB_WORD_W+`FB_WORD_W/8-1:0]     wdat_q [$]; // {mask, data}
    logic [`FB_WORD_W-1:0]                  rd_q [$];

    int seed = SEED;
    int lat_cnt;

    // unwritten words read back as a spread of the word address
    function automatic logic [`FB_WORD_W-1:0] fill_word(input logic [27:0] waddr);
        return 32'h9e37_79b9 * {4'd0, waddr};
    endfunction

    function automatic logic [`FB_WORD_W-1:0] load(input logic [27:0] waddr);
        if (mem.exists(int'(waddr))) begin
            return mem[int'(waddr)];
        end
        return fill_word(waddr);
    endfunction

    always @(posedge clk) begin
        mem_cmd_t                           head;
        logic [`FB_WORD_W+`FB_WORD_W/8-1:0] wd;
        logic [27:0]                        waddr;
        logic [`FB_WORD_W-1:0]              word;
        if (rst) begin
            cmd_q.delete();
            wdat_q.delete();
            rd_q.delete();
            lat_cnt = 0;
            cmd_full_o <= 1'b0;
            wr_full_o  <= 1'b0;
            rd_empty_o <= 1'b1;
            rd_data_o  <= '0;
        end else begin
            if (cmd_en_i) cmd_q.push_back(cmd_i);
            if (wr_en_i) wdat_q.push_back({wr_mask_i, wr_data_i});
            if (rd_en_i && rd_q.size() > 0) void'(rd_q.pop_front());

            // commands retire strictly in order, each after a random delay
            if (cmd_q.size() > 0) begin
                if (lat_cnt > 0) begin
                    lat_cnt--;
                end else begin
                    head  = cmd_q[0];
                    waddr = head.byte_addr[`FB_ADDR_W-1:2];
                    if (head.instr == MEM_READ) begin
                        rd_q.push_back(load(waddr));
                        void'(cmd_q.pop_front());
                        lat_cnt = $random(seed) & 7;
                    end else if (wdat_q.size() > 0) begin
                        wd   = wdat_q.pop_front();
                        word = load(waddr);
                        for (int b = 0; b < `FB_WORD_W/8; b++) begin
                            if (!wd[`FB_WORD_W + b]) word[8*b +: 8] = wd[8*b +: 8];
                        end
                        mem[int'(waddr)] = word;
                        void'(cmd_q.pop_front());
                        lat_cnt = $random(seed) & 7;
                    end
                end
            end

            cmd_full_o <= (cmd_q.size() >= DEPTH - 1) || (($random(seed) & 3) == 0);
            wr_full_o  <= (wdat_q.size() >= DEPTH - 1);
            rd_empty_o <= (rd_q.size() == 0);
            rd_data_o  <= (rd_q.size() > 0) ? rd_q[0] : '0;
        end
    end

endmodule

//--- test/fb_tb.sv
`timescale 1ns/1ps
`include "fb_params.svh"

module fb_tb
    import fb_pkg::*;
();

    localparam int TIMEOUT = 1000;

    typedef struct packed {
        pix_addr_t addr;
        pixel_t    pix;
    } exp_t;

    logic clk = 1'b0;
    logic rst;

    logic                          s_awvalid, s_awready, s_wvalid, s_wready;
    logic [`FB_AXI_ADDR_W-1:0]     s_awaddr;
    logic [`FB_WORD_W-1:0]         s_wdata;
    logic [`FB_WORD_W/8-1:0]       s_wstrb;
    logic                          s_bvalid, s_bready;
    logic [1:0]                    s_bresp;
    logic                          req_valid, req_ready, resp_valid;
    pix_addr_t                     req_addr;
    pixel_t                        resp_pix;
    logic                          mem_cmd_en, mem_cmd_full, mem_wr_en, mem_wr_full;
    mem_cmd_t                      mem_cmd;
    logic [`FB_WORD_W-1:0]         mem_wr_data, mem_rd_data;
    logic [`FB_WORD_W/8-1:0]       mem_wr_mask;
    logic                          mem_rd_en, mem_rd_empty;

    int          seed = 14443;
    int          value_errors;
    int          timeout_errors;
    int          n_acc;
    int          n_resp;
    string       test_name;
    logic [31:0] ref_mem [int]; // reference pixel words, by pixel index
    exp_t        exp_q [$];
    pix_addr_t   addr_list [$];

    always #20 clk = ~clk;

    fb_top i_fb_top (
        .clk (clk), .rst (rst),
        .s_awvalid_i (s_awvalid), .s_awready_o (s_awready), .s_awaddr_i (s_awaddr),
        .s_wvalid_i (s_wvalid), .s_wready_o (s_wready), .s_wdata_i (s_wdata),
        .s_wstrb_i (s_wstrb), .s_bvalid_o (s_bvalid), .s_bready_i (s_bready),
        .s_bresp_o (s_bresp),
        .req_valid_i (req_valid), .req_addr_i (req_addr), .req_ready_o (req_ready),
        .resp_valid_o (resp_valid), .resp_pix_o (resp_pix),
        .mem_cmd_en_o (mem_cmd_en), .mem_cmd_o (mem_cmd), .mem_cmd_full_i (mem_cmd_full),
        .mem_wr_en_o (mem_wr_en), .mem_wr_data_o (mem_wr_data),
        .mem_wr_mask_o (mem_wr_mask), .mem_wr_full_i (mem_wr_full),
        .mem_rd_en_o (mem_rd_en), .mem_rd_data_i (mem_rd_data),
        .mem_rd_empty_i (mem_rd_empty)
    );

    mig_port_model i_mig_port_model (
        .clk (clk), .rst (rst),
        .cmd_en_i (mem_cmd_en), .cmd_i (mem_cmd), .cmd_full_o (mem_cmd_full),
        .wr_en_i (mem_wr_en), .wr_data_i (mem_wr_data), .wr_mask_i (mem_wr_mask),
        .wr_full_o (mem_wr_full),
        .rd_en_i (mem_rd_en), .rd_data_o (mem_rd_data), .rd_empty_o (mem_rd_empty)
    );

    // contents of a word that was never written
    function automatic logic [31:0] fill_word(input pix_addr_t a);
        return 32'h9e37_79b9 * {16'd0, a};
    endfunction

    function automatic logic [31:0] stored_word(input pix_addr_t a);
        if (ref_mem.exists(int'(a))) begin
            return ref_mem[int'(a)];
        end
        return fill_word(a);
    endfunction

    function automatic logic [31:0] strobe_merge(input logic [31:0] old, input logic [31:0] d,
                                                 input logic [3:0] s);
        logic [31:0] w;
        w = old;
        for (int b = 0; b < 4; b++) begin
            if (s[b]) w[8*b +: 8] = d[8*b +: 8];
        end
        return w;
    endfunction

    // red 21:16, green 13:8, blue 5:0
    function automatic pixel_t pixel_of(input logic [31:0] w);
        pixel_t p;
        p.r = w[21:16];
        p.g = w[13:8];
        p.b = w[5:0];
        return p;
    endfunction

    function automatic pix_addr_t random_addr();
        return 16'($random(seed));
    endfunction

    task automatic check_low(input string what, input logic v);
        if (v !== 1'b0) begin
            value_errors++;
            $display("Error: %s %s expected 0 actual %b", test_name, what, v);
        end
    endtask

    task automatic host_write(input pix_addr_t a, input logic [31:0] d, input logic [3:0] s);
        int t;
        bit aw_done;
        bit w_done;
        bit b_done;
        t = 0;
        aw_done = 1'b0;
        w_done = 1'b0;
        b_done = 1'b0;
        @(posedge clk);
        s_awvalid <= 1'b1;
        s_awaddr  <= {14'd0, a, 2'b00};
        s_wvalid  <= ($random(seed) & 1) != 0; // data sometimes trails the address
        s_wdata   <= d;
        s_wstrb   <= s;
        while (!(aw_done && w_done) && t < TIMEOUT) begin
            @(negedge clk);
            if (s_awvalid && s_awready) aw_done = 1'b1;
            if (s_wvalid && s_wready) w_done = 1'b1;
            @(posedge clk);
            if (aw_done) s_awvalid <= 1'b0;
            s_wvalid <= !w_done;
            t++;
        end
        if (!(aw_done && w_done)) begin
            timeout_errors++;
            $display("%s: host write address or data was never accepted", test_name);
            s_awvalid <= 1'b0;
            s_wvalid  <= 1'b0;
        end else begin
            t = 0;
            while (!b_done && t < TIMEOUT) begin
                s_bready <= ($random(seed) & 1) != 0;
                @(negedge clk);
                if (s_bvalid && s_bready) begin
                    b_done = 1'b1;
                    if (s_bresp !== 2'b00) begin
                        value_errors++;
                        $display("Error: %s bresp expected 0 actual %0d", test_name, s_bresp);
                    end
                end
                @(posedge clk);
                t++;
            end
            s_bready <= 1'b0;
            if (b_done) begin
                ref_mem[int'(a)] = strobe_merge(stored_word(a), d, s);
            end else begin
                timeout_errors++;
                $display("%s: no write response from the host port", test_name);
            end
        end
    endtask

    // issues every address in addr_list back to back
    task automatic lcd_reads();
        int t;
        t = 0;
        if (addr_list.size() > 0) begin
            @(posedge clk);
            req_valid <= 1'b1;
            req_addr  <= addr_list[0];
            while (addr_list.size() > 0 && t < TIMEOUT) begin
                @(negedge clk);
                if (req_ready) begin
                    void'(addr_list.pop_front());
                    t = 0;
                end else begin
                    t++;
                end
                @(posedge clk);
                if (addr_list.size() > 0) req_addr <= addr_list[0];
                else req_valid <= 1'b0;
            end
            if (addr_list.size() > 0) begin
                timeout_errors++;
                $display("%s: LCD request was never accepted", test_name);
                req_valid <= 1'b0;
                addr_list.delete();
            end
        end
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while (exp_q.size() > 0 && t < TIMEOUT) begin
            @(posedge clk);
            t++;
        end
        if (exp_q.size() > 0) begin
            timeout_errors++;
            $display("%s: %0d LCD responses never arrived", test_name, exp_q.size());
            exp_q.delete();
        end
    endtask

    // lcd side monitor, sampled mid cycle
    always @(negedge clk) begin
        exp_t e;
        if (!rst) begin
            if (req_ready && (n_acc - n_resp) >= `FB_MAX_RD) begin
                value_errors++;
                $display("%s: req_ready high with %0d reads outstanding",
                         test_name, n_acc - n_resp);
            end
            if (mem_cmd_en && mem_cmd_full) begin
                value_errors++;
                $display("%s: memory command issued while the command FIFO was full",
                         test_name);
            end
            if (mem_rd_en && mem_rd_empty) begin
                value_errors++;
                $display("%s: read FIFO popped while empty", test_name);
            end
            if (mem_cmd_en && mem_cmd.bl !== 6'd0) begin
                value_errors++;
                $display("Error: %s mem_cmd bl expected 0 actual %0d", test_name, mem_cmd.bl);
            end
            if (resp_valid) begin
                if (exp_q.size() == 0) begin
                    value_errors++;
                    $display("%s: LCD response without a pending request", test_name);
                end else begin
                    e = exp_q.pop_front();
                    if (resp_pix !== e.pix) begin
                        value_errors++;
                        $display("Error: %s pixel y=%0d x=%0d expected %h actual %h",
                                 test_name, e.addr.y, e.addr.x, e.pix, resp_pix);
                    end
                end
                n_resp++;
            end
            if (req_valid && req_ready) begin
                e.addr = req_addr;
                e.pix  = pixel_of(stored_word(req_addr)); // what the model holds right now
                exp_q.push_back(e);
                n_acc++;
            end
        end
    end

    initial begin
        pix_addr_t a;
        pix_addr_t wr_addrs [$];
        int        n;
        rst = 1'b1;
        s_awvalid = 1'b0;
        s_awaddr = '0;
        s_wvalid = 1'b0;
        s_wdata = '0;
        s_wstrb = '0;
        s_bready = 1'b0;
        req_valid = 1'b0;
        req_addr = '0;
        value_errors = 0;
        timeout_errors = 0;
        n_acc = 0;
        n_resp = 0;
        test_name = "reset";
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        check_low("bvalid", s_bvalid);
        check_low("resp_valid", resp_valid);
        check_low("mem_cmd_en", mem_cmd_en);
        check_low("mem_wr_en", mem_wr_en);
        check_low("mem_rd_en", mem_rd_en);

        test_name = "single_write";
        a = random_addr();
        host_write(a, $random(seed), 4'hf);
        addr_list.push_back(a);
        lcd_reads();
        wait_drain();

        test_name = "strobe_writes";
        for (int i = 0; i < 200; i++) begin
            a = random_addr();
            host_write(a, $random(seed), 4'($random(seed)));
            wr_addrs.push_back(a);
        end
        addr_list = wr_addrs;
        lcd_reads();
        wait_drain();

        test_name = "read_burst";
        for (int i = 0; i < 120; i++) begin
            if (($random(seed) & 1) != 0) addr_list.push_back(random_addr());
            else addr_list.push_back(wr_addrs[$unsigned($random(seed)) % wr_addrs.size()]);
        end
        lcd_reads();
        wait_drain();

        test_name = "mixed";
        for (int i = 0; i < 150; i++) begin
            if (($random(seed) & 1) != 0) begin
                a = random_addr();
                host_write(a, $random(seed), 4'($random(seed)));
                if (($random(seed) & 1) != 0) begin
                    addr_list.push_back(a); // read straight back after bresp
                    lcd_reads();
                end
            end else begin
                n = 1 + ($random(seed) & 3);
                repeat (n) addr_list.push_back(wr_addrs[$unsigned($random(seed)) % wr_addrs.size()]);
                lcd_reads();
            end
        end
        wait_drain();

        repeat (5) @(posedge clk);
        $display("errors: %0d value, %0d timeout", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- fb_top.f
+incdir+include
source/fb_pkg.sv
source/fb_host_wr.sv
source/fb_cmd_issue.sv
source/fb_rd_unpack.sv
source/fb_top.sv
test/mig_port_model.sv
test/fb_tb.sv

//--- Makefile
TB_TOP = fb_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f fb_top.f --top-module $(TB_TOP)

run: build
	@out="$$(./obj_dir/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL TESTS PASSED"

lint:
	verilator --lint-only -Wall -f fb_top.f --top-module fb_top

clean:
	rm -rf obj_dir
